//--- list.f
common/fetch_pkg.sv
ifu/ifu_pc_ctrl.sv
ifu/l1i_cache.sv
rtl/fetch_top.sv
verification/wb_imem_model.sv
verification/fetch_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -f list.f --top-module fetch_tb
	./obj_dir/Vfetch_tb | tee /dev/stderr | grep "^Test passed$$" > /dev/null

clean:
	rm -rf obj_dir

//--- verification/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;
  import fetch_pkg::*;

  logic  clk;
  logic  rst;
  logic  ready_i;
  logic  redirect_i;
  logic  retire_i;
  word_t redirect_pc_i;
  word_t retire_pc_i;
  logic  valid_o;
  logic  spec_o;
  logic  good_spec_o;
  logic  bad_spec_o;
  word_t pc_o;
  word_t inst_o;
  logic  wb_cyc_o;
  logic  wb_stb_o;
  logic  wb_ack_i;
  word_t wb_adr_o;
  word_t wb_dat_i;

  int errs [1:6];
  int seed;
  int cycles;
  int total;
  int jal_count;
  int br_count;
  word_t arch_pc;
  // backend response pipe, 1 = redirect, 2 = retire
  logic [1:0] resp_kind [3];
  word_t resp_pc [3];
  logic stalled;
  logic fence_pend;
  logic after_bad;
  logic saw_good;
  logic saw_bad;
  logic restart_ok;
  logic done;
  logic first_bus_seen;
  logic beat;
  logic prev_valid;
  logic prev_ready;
  logic prev_bad;
  logic prev_cyc;
  logic prev_spec;
  word_t line_adr;
  word_t prev_pc;
  word_t prev_inst;

  fetch_top dut0 (
    .clk           (clk),
    .rst           (rst),
    .valid_o       (valid_o),
    .ready_i       (ready_i),
    .pc_o          (pc_o),
    .inst_o        (inst_o),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .retire_i      (retire_i),
    .retire_pc_i   (retire_pc_i),
    .spec_o        (spec_o),
    .good_spec_o   (good_spec_o),
    .bad_spec_o    (bad_spec_o),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i)
  );

  wb_imem_model mem0 (
    .clk   (clk),
    .rst   (rst),
    .cyc_i (wb_cyc_o),
    .stb_i (wb_stb_o),
    .adr_i (wb_adr_o),
    .dat_o (wb_dat_i),
    .ack_o (wb_ack_i)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic word_t jal_imm(input word_t w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic word_t br_imm(input word_t w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  task automatic report_value(input int t, input string name, input word_t got, input word_t exp);
    $display("[FAIL] t=%0t %s: got %h expected %h", $time, name, got, exp);
    errs[t]++;
  endtask

  task automatic report_text(input int t, input string msg);
    $display("[FAIL] t=%0t %s", $time, msg);
    errs[t]++;
  endtask

  // architectural step for an instruction on the right path
  task automatic take_instr(input word_t pc, input word_t inst);
    word_t off;
    word_t w;
    off = pc - PC_INIT;
    w = mem0.prog[off[5:2]];
    assert (inst == w) else report_value(2, "inst_o", inst, w);
    if (after_bad) begin
      restart_ok = 1'b1;
      after_bad  = 1'b0;
    end
    arch_pc = pc + 32'd4;
    if (inst[6:0] == OP_JAL) begin
      jal_count++;
      arch_pc = pc + jal_imm(inst);
      resp_kind[2] = 2'd1;
    end else if (inst[6:0] == OP_BRANCH) begin
      br_count++;
      // loop exit on the third visit
      if (br_count == 3) begin
        arch_pc = pc + br_imm(inst);
        resp_kind[2] = 2'd1;
      end else begin
        resp_kind[2] = 2'd2;
      end
    end else if (inst[6:0] == OP_LOAD || inst == INST_FENCE_I) begin
      resp_kind[2] = 2'd2;
      stalled = 1'b1;
      fence_pend = inst == INST_FENCE_I;
    end
    resp_pc[2] = (resp_kind[2] == 2'd1) ? arch_pc : pc;
    if (off == 32'h2c) begin
      done = 1'b1;
    end
  endtask

  always @(posedge clk) begin : backend
    logic [1:0] out_kind;
    word_t out_pc;
    word_t r;
    if (!rst) begin
      // hold under back-pressure
      if (prev_valid && !prev_ready && !prev_bad) begin
        assert (valid_o) else report_text(6, "valid_o dropped before the transfer");
        assert (pc_o == prev_pc) else report_value(6, "pc_o", pc_o, prev_pc);
        assert (inst_o == prev_inst) else report_value(6, "inst_o", inst_o, prev_inst);
      end
      if (stalled) begin
        assert (!valid_o) else report_text(4, "valid_o rose before the backend responded");
        if (redirect_i || retire_i) begin
          stalled = 1'b0;
        end
      end
      assert (wb_stb_o == wb_cyc_o) else report_text(3, "wb_stb_o differs from wb_cyc_o");
      if (wb_cyc_o && !prev_cyc) begin
        if (!first_bus_seen) begin
          first_bus_seen = 1'b1;
          assert (wb_adr_o == PC_INIT) else report_value(1, "wb_adr_o", wb_adr_o, PC_INIT);
        end
        assert (jal_count < 1 || arch_pc < PC_INIT + 32'h10 || arch_pc > PC_INIT + 32'h18)
          else report_text(3, "bus cycle during a cached loop pass");
        fence_pend = 1'b0;
      end
      if (wb_cyc_o && wb_ack_i) begin
        if (!beat) begin
          assert (wb_adr_o[2:0] == 3'd0)
            else report_value(3, "wb_adr_o", wb_adr_o, {wb_adr_o[31:3], 3'b000});
          line_adr = wb_adr_o;
        end else begin
          assert (wb_adr_o == line_adr + 32'd4)
            else report_value(3, "wb_adr_o", wb_adr_o, line_adr + 32'd4);
        end
        beat = !beat;
      end
      if (good_spec_o) begin
        assert (prev_spec) else report_text(5, "good_spec_o without spec_o before it");
        saw_good = 1'b1;
      end
      if (bad_spec_o) begin
        saw_bad   = 1'b1;
        after_bad = 1'b1;
      end
      out_kind = resp_kind[0];
      out_pc   = resp_pc[0];
      resp_kind[0] = resp_kind[1];
      resp_pc[0]   = resp_pc[1];
      resp_kind[1] = resp_kind[2];
      resp_pc[1]   = resp_pc[2];
      resp_kind[2] = 2'd0;
      if (valid_o && ready_i && !bad_spec_o) begin
        assert (!fence_pend) else report_text(4, "fetch after fence.i did not use the bus");
        if (pc_o == arch_pc) begin
          take_instr(pc_o, inst_o);
        end else begin
          assert (spec_o) else report_value(2, "pc_o", pc_o, arch_pc);
        end
      end
      prev_valid = valid_o;
      prev_ready = ready_i;
      prev_bad   = bad_spec_o;
      prev_cyc   = wb_cyc_o;
      prev_spec  = spec_o;
      prev_pc    = pc_o;
      prev_inst  = inst_o;
      #2;
      r = $random(seed);
      ready_i       = r[1:0] != 2'b00;
      redirect_i    = out_kind == 2'd1;
      retire_i      = out_kind == 2'd2;
      redirect_pc_i = out_pc;
      retire_pc_i   = out_pc;
    end
  end

  initial begin
    seed = 32'hafe95c6f;
    rst = 1'b1;
    ready_i = 1'b0;
    redirect_i = 1'b0;
    retire_i = 1'b0;
    redirect_pc_i = '0;
    retire_pc_i = '0;
    for (int i = 0; i < 3; i++) begin
      resp_kind[i] = 2'd0;
      resp_pc[i] = '0;
    end
    for (int t = 1; t <= 6; t++) errs[t] = 0;
    {stalled, fence_pend, after_bad, saw_good, saw_bad} = '0;
    {restart_ok, done, first_bus_seen, beat} = '0;
    {prev_valid, prev_ready, prev_bad, prev_cyc, prev_spec} = '0;
    jal_count = 0;
    br_count = 0;
    arch_pc = PC_INIT;
    line_adr = '0;
    prev_pc = '0;
    prev_inst = '0;
    repeat (5) @(posedge clk);
    #1;
    assert (!valid_o && !wb_cyc_o && !wb_stb_o)
      else report_text(1, "valid_o, wb_cyc_o or wb_stb_o high in reset");
    assert (!spec_o && !good_spec_o && !bad_spec_o)
      else report_text(1, "speculation output high in reset");
    assert (pc_o == PC_INIT) else report_value(1, "pc_o", pc_o, PC_INIT);
    #1 rst = 1'b0;
    cycles = 0;
    while (!done && cycles < 4000) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (done) else report_text(2, "timeout, program end never reached");
    assert (first_bus_seen) else report_text(1, "no bus cycle after reset");
    assert (saw_good) else report_text(5, "no good_spec_o pulse");
    assert (saw_bad) else report_text(5, "no bad_spec_o");
    assert (restart_ok) else report_text(5, "no instruction accepted after the restart");
    total = 0;
    for (int t = 1; t <= 6; t++) begin
      $display("test %0d: %s (%0d errors)", t, errs[t] == 0 ? "ok" : "FAIL", errs[t]);
      total += errs[t];
    end
    $display("checks done: %0d errors over 6 tests, %0d cycles", total, cycles);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verification/wb_imem_model.sv
`timescale 1ns/10ps

module wb_imem_model
  import fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  cyc_i,
  input  logic  stb_i,
  input  word_t adr_i,
  output word_t dat_o,
  output logic  ack_o
);

  word_t prog [16];
  int seed;
  logic [1:0] wait_q;

  // addi x0,x0,imm outside the program, imm taken from the whole address
  function automatic word_t read_word(input word_t adr);
    word_t off;
    logic [11:0] imm;
    off = adr - PC_INIT;
    imm = adr[11:0] ^ adr[23:12] ^ {4'h0, adr[31:24]};
    if (off < 32'd64) begin
      return prog[off[5:2]];
    end
    return {imm, 20'h00013};
  endfunction

  initial begin
    seed = 32'hafe95c6f;
    for (int i = 0; i < 16; i++) begin
      prog[i] = {12'(i), 20'h00013};
    end
    prog[0]  = 32'h0010_0093;
    prog[1]  = 32'h0000_0013;
    prog[2]  = 32'h0000_2103;
    prog[3]  = 32'h0000_0013;
    // loop head
    prog[4]  = 32'h0000_0013;
    // bne x2,x1 exits the loop to the fence.i
    prog[5]  = 32'h0011_1663;
    // jal x0,-8
    prog[6]  = 32'hff9f_f06f;
    prog[7]  = 32'h0000_0013;
    prog[8]  = INST_FENCE_I;
    prog[9]  = 32'h0020_0113;
    prog[10] = 32'h0000_0013;
    prog[11] = 32'h0000_0013;
  end

  // one-cycle ack after a random wait of zero to three cycles
  always @(posedge clk) begin : ack_gen
    word_t r;
    if (rst) begin
      ack_o  <= 1'b0;
      wait_q <= 2'd0;
      dat_o  <= '0;
    end else if (ack_o) begin
      ack_o <= 1'b0;
    end else if (cyc_i && stb_i) begin
      if (wait_q == 2'd0) begin
        r = $random(seed);
        ack_o  <= 1'b1;
        dat_o  <= read_word(adr_i);
        wait_q <= r[1:0];
      end else begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/10ps

module fetch_top
  import fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  output logic  valid_o,
  input  logic  ready_i,
  output word_t pc_o,
  output word_t inst_o,
  input  logic  redirect_i,
  input  word_t redirect_pc_i,
  input  logic  retire_i,
  input  word_t retire_pc_i,
  output logic  spec_o,
  output logic  good_spec_o,
  output logic  bad_spec_o,
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output word_t wb_adr_o,
  input  word_t wb_dat_i,
  input  logic  wb_ack_i
);

  word_t fetch_pc;
  word_t cache_inst;
  logic  cache_hit;
  logic  cache_idle;
  logic  invalidate;

  ifu_pc_ctrl u_pc_ctrl (
    .clk           (clk),
    .rst           (rst),
    .ready_i       (ready_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .retire_i      (retire_i),
    .retire_pc_i   (retire_pc_i),
    .hit_i         (cache_hit),
    .inst_i        (cache_inst),
    .cache_idle_i  (cache_idle),
    .valid_o       (valid_o),
    .pc_o          (pc_o),
    .inst_o        (inst_o),
    .fetch_pc_o    (fetch_pc),
    .invalidate_o  (invalidate),
    .spec_o        (spec_o),
    .good_spec_o   (good_spec_o),
    .bad_spec_o    (bad_spec_o)
  );

  l1i_cache u_l1i (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc_i   (fetch_pc),
    .invalidate_i (invalidate),
    .hit_o        (cache_hit),
    .inst_o       (cache_inst),
    .idle_o       (cache_idle),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i)
  );

endmodule

//--- ifu/l1i_cache.sv
`timescale 1ns/10ps

module l1i_cache
  import fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  word_t fetch_pc_i,
  input  logic  invalidate_i,
  output logic  hit_o,
  output word_t inst_o,
  output logic  idle_o,
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output word_t wb_adr_o,
  input  word_t wb_dat_i,
  input  logic  wb_ack_i
);

  localparam int SETS = 2 ** L1I_SETS_LOG2;
  localparam int LINE_WORDS = 2 ** L1I_LINE_LOG2;

  refill_state_e state_q;

  word_t data_q [SETS][LINE_WORDS];
  tag_t  tag_q [SETS];
  logic [SETS-1:0] valid_q;

  tag_t     refill_tag_q;
  set_idx_t refill_set_q;
  logic     cyc_q;

  tag_t     pc_tag;
  set_idx_t pc_set;
  logic [L1I_LINE_LOG2-1:0] pc_word;
  logic [L1I_LINE_LOG2-1:0] beat;
  logic     ack;

  // pc = tag | set | word | byte
  assign pc_tag  = fetch_pc_i[XLEN-1:XLEN-TAG_W];
  assign pc_set  = fetch_pc_i[L1I_SETS_LOG2+L1I_LINE_LOG2+1:L1I_LINE_LOG2+2];
  assign pc_word = fetch_pc_i[L1I_LINE_LOG2+1:2];

  assign hit_o  = (state_q == LOOKUP) && valid_q[pc_set] && (tag_q[pc_set] == pc_tag);
  assign inst_o = data_q[pc_set][pc_word];
  assign idle_o = state_q == LOOKUP;

  // even word first, then the odd one
  assign beat = (state_q == BEAT1) ? 1'b1 : 1'b0;
  assign ack  = cyc_q && wb_ack_i;

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = {refill_tag_q, refill_set_q, beat, 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= LOOKUP;
      cyc_q   <= 1'b0;
      valid_q <= '0;
    end else begin
      case (state_q)
        LOOKUP: begin
          if (!hit_o) begin
            state_q <= BEAT0;
            cyc_q   <= 1'b1;
          end
        end
        BEAT0: begin
          if (ack) begin
            state_q <= BEAT1;
            cyc_q   <= 1'b0;
          end
        end
        BEAT1: begin
          // one idle cycle between the two reads
          if (!cyc_q) begin
            cyc_q <= 1'b1;
          end else if (wb_ack_i) begin
            state_q <= FILL_DONE;
            cyc_q   <= 1'b0;
            valid_q[refill_set_q] <= 1'b1;
          end
        end
        FILL_DONE: state_q <= LOOKUP;
        default: state_q <= LOOKUP;
      endcase
      if (invalidate_i) begin
        valid_q <= '0;
      end
    end
  end

  // line address is latched at the miss
  always_ff @(posedge clk) begin
    if ((state_q == LOOKUP) && !hit_o) begin
      refill_tag_q <= pc_tag;
      refill_set_q <= pc_set;
    end
    if (ack) begin
      data_q[refill_set_q][beat] <= wb_dat_i;
      tag_q[refill_set_q]        <= refill_tag_q;
    end
  end

endmodule

//--- ifu/ifu_pc_ctrl.sv
`timescale 1ns/10ps

module ifu_pc_ctrl
  import fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  ready_i,
  input  logic  redirect_i,
  input  word_t redirect_pc_i,
  input  logic  retire_i,
  input  word_t retire_pc_i,
  input  logic  hit_i,
  input  word_t inst_i,
  input  logic  cache_idle_i,
  output logic  valid_o,
  output word_t pc_o,
  output word_t inst_o,
  output word_t fetch_pc_o,
  output logic  invalidate_o,
  output logic  spec_o,
  output logic  good_spec_o,
  output logic  bad_spec_o
);

  fetch_state_e state_q;

  word_t pc_q;
  word_t btb_q;
  word_t spec_pc_q;
  word_t spec_fall_q;
  word_t restart_pc_q;
  word_t resolved_pc;

  logic btb_valid_q;
  logic spec_q;
  logic spec_cond_q;
  logic hazard_q;
  logic bad_q;
  logic good_q;

  logic [6:0] opcode;
  logic is_cond;
  logic is_jump;
  logic is_load;
  logic is_store;
  logic is_fence;
  logic resolved;
  logic spec_match;
  logic good_now;
  logic bad_now;
  logic squash;
  logic can_offer;
  logic accept;
  logic predict;
  logic restart;

  // predecode of the word on offer
  assign opcode   = inst_i[6:0];
  assign is_cond  = opcode == OP_BRANCH;
  assign is_jump  = (opcode == OP_JAL) || (opcode == OP_JALR) || is_cond;
  assign is_load  = opcode == OP_LOAD;
  assign is_store = opcode == OP_STORE;
  assign is_fence = inst_i == INST_FENCE_I;

  // next pc as resolved by the backend
  assign resolved    = redirect_i || retire_i;
  assign resolved_pc = redirect_i ? redirect_pc_i : retire_pc_i + 32'd4;

  assign spec_match = resolved_pc == spec_pc_q;
  assign good_now   = spec_q && resolved && spec_match;
  assign bad_now    = spec_q && resolved && !spec_match;
  assign squash     = bad_q || bad_now;

  // memory ops wait until the guess is confirmed
  assign can_offer = !hazard_q && !squash && !(spec_q && (is_load || is_store));

  // once offered, valid holds until the transfer
  assign valid_o = hit_i && ((state_q == WAIT_READY) || can_offer);

  assign accept  = valid_o && ready_i && !squash;
  assign predict = accept && is_jump && btb_valid_q && !spec_q;
  assign restart = bad_q && (state_q == IDLE) && cache_idle_i;

  assign invalidate_o = accept && is_fence;

  assign pc_o        = pc_q;
  assign fetch_pc_o  = pc_q;
  assign inst_o      = inst_i;
  assign spec_o      = spec_q;
  assign good_spec_o = good_q;
  assign bad_spec_o  = bad_q || bad_now;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      pc_q        <= PC_INIT;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      hazard_q    <= 1'b0;
      bad_q       <= 1'b0;
      good_q      <= 1'b0;
    end else begin
      good_q <= good_now;
      if (redirect_i) begin
        btb_valid_q <= 1'b1;
      end
      if (good_now || bad_now) begin
        spec_q <= 1'b0;
      end
      if (bad_now) begin
        bad_q <= 1'b1;
      end
      // stall released by the matching response
      if (hazard_q && !spec_q && resolved) begin
        hazard_q <= 1'b0;
        pc_q     <= resolved_pc;
      end
      if (restart) begin
        bad_q    <= 1'b0;
        hazard_q <= 1'b0;
        pc_q     <= restart_pc_q;
      end
      if (accept) begin
        if (is_load || is_fence) begin
          hazard_q <= 1'b1;
        end else if (is_jump) begin
          if (predict) begin
            pc_q   <= btb_q;
            spec_q <= 1'b1;
          end else begin
            hazard_q <= 1'b1;
          end
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
      case (state_q)
        IDLE: begin
          if (valid_o && !ready_i) begin
            state_q <= WAIT_READY;
          end
        end
        WAIT_READY: begin
          if (ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // target buffer and prediction bookkeeping
  always_ff @(posedge clk) begin
    if (redirect_i) begin
      btb_q <= redirect_pc_i;
    end
    if (predict) begin
      spec_pc_q   <= btb_q;
      spec_fall_q <= pc_q + 32'd4;
      spec_cond_q <= is_cond;
    end
    if (bad_now) begin
      // untaken branch falls through
      restart_pc_q <= (retire_i && !redirect_i && spec_cond_q) ? spec_fall_q : resolved_pc;
    end
  end

endmodule

//--- common/fetch_pkg.sv
package fetch_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // reset vector
  localparam word_t PC_INIT = 32'h8000_0000;

  // l1i geometry: four sets, two words per line
  localparam int L1I_SETS_LOG2 = 2;
  localparam int L1I_LINE_LOG2 = 1;
  localparam int TAG_W = XLEN - L1I_SETS_LOG2 - L1I_LINE_LOG2 - 2;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [L1I_SETS_LOG2-1:0] set_idx_t;

  // rv32i major opcodes
  localparam logic [6:0] OP_JAL    = 7'b110_1111;
  localparam logic [6:0] OP_JALR   = 7'b110_0111;
  localparam logic [6:0] OP_BRANCH = 7'b110_0011;
  localparam logic [6:0] OP_LOAD   = 7'b000_0011;
  localparam logic [6:0] OP_STORE  = 7'b010_0011;

  // fence.i with all fields zero
  localparam word_t INST_FENCE_I = 32'h0000_100f;

  typedef enum logic {
    IDLE,
    WAIT_READY
  } fetch_state_e;

  typedef enum logic [1:0] {
    LOOKUP,
    BEAT0,
    BEAT1,
    FILL_DONE
  } refill_state_e;

endpackage
